/* compile.f */
rtl/code_pkg.sv
rtl/signal_pkg.sv
rtl/ca_upsampler.sv
rtl/carrier_nco.sv
rtl/track.sv
rtl/subchannel.sv
tb/subchannel_properties.sv
tb/subchannel_tb.sv

/* run.sh */
#!/bin/sh
# Builds the subchannel testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module subchannel_tb \
      -Mdir obj_dir -o subchannel_sim -f compile.f; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/subchannel_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation passed"; then
   exit 0
fi
exit 1

/* tb/subchannel_tb.sv */
`timescale 1ns/1ps

module subchannel_tb;

   localparam int RESET_CYCLES = 4;
   localparam int PRN1_SAMPLES = 20;
   localparam int PERIOD_CYCLES = 2300;
   localparam int RANDOM_CYCLES = 1500;
   localparam int NUM_SEEKS = 3;
   localparam int AFTER_SEEK_CYCLES = 100;
   localparam int SEEK_BOUND = 2046;
   // All test phases, every seek at its longest, plus slack.
   localparam int TIMEOUT_LIMIT = 2 * RESET_CYCLES + PRN1_SAMPLES + PERIOD_CYCLES
                                + RANDOM_CYCLES + NUM_SEEKS * (AFTER_SEEK_CYCLES + 1)
                                + NUM_SEEKS * SEEK_BOUND + 200;

   // First ten chips of PRN 1, octal 1440, first chip in the MSB.
   localparam logic [9:0] PRN1_FIRST_CHIPS = 10'o1440;

   // G2 stage pairs per PRN from the C/A code assignment table.
   localparam int TAP_A [32] = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2, 3, 5, 6, 7, 8, 9,
                                 1, 2, 3, 4, 5, 6, 1, 4, 5, 6, 7, 8, 1, 2, 3, 4};
   localparam int TAP_B [32] = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3, 4, 6, 7, 8, 9, 10,
                                 4, 5, 6, 7, 8, 9, 3, 6, 7, 8, 9, 10, 6, 7, 8, 9};
   localparam int COS_TABLE [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
   localparam int SIN_TABLE [8] = '{1, 2, 2, 1, -1, -2, -2, -1};

   logic                  clk_i = 1'b0;
   logic                  reset_i;
   logic                  clear_i;
   logic                  data_available_i;
   logic                  feed_complete_i;
   signal_pkg::sample_t   data_i;
   signal_pkg::doppler_t  doppler_i;
   code_pkg::prn_t        prn_i;
   logic                  seek_en_i;
   code_pkg::code_shift_t seek_target_i;
   logic                  seeking_o;
   code_pkg::code_shift_t code_shift_o;
   logic                  ca_bit_o;
   logic                  accumulator_updating_o;
   signal_pkg::acc_t      accumulator_i_o;
   signal_pkg::acc_t      accumulator_q_o;
   logic                  accumulation_complete_o;

   integer seed;
   int     cycle_count = 0;

   // Reference model state, stages numbered 1 to 10.
   int                 m_prn;
   logic [10:1]        m_g1;
   logic [10:1]        m_g2;
   int                 m_shift;
   int                 m_target;
   logic               m_seeking;
   logic [15:0]        m_phase;
   logic signed [19:0] m_acc_i;
   logic signed [19:0] m_acc_q;
   logic               exp_updating;
   logic               exp_complete;
   logic               pipe_valid [3];
   logic               pipe_last [3];
   int                 pipe_i [3];
   int                 pipe_q [3];

   subchannel UUT (.*);

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_LIMIT) begin
         $display("Timeout: the run went past %0d clock cycles", TIMEOUT_LIMIT);
         $display("Simulation failed");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   function automatic logic model_chip();
      return m_g1[10] ^ m_g2[TAP_A[m_prn]] ^ m_g2[TAP_B[m_prn]];
   endfunction

   // One sample of code, a new chip on every even shift.
   task automatic advance_code();
      if (m_shift == SEEK_BOUND - 1) begin
         m_shift = 0;
         m_g1    = '1;
         m_g2    = '1;
      end else begin
         m_shift++;
         if (m_shift % 2 == 0) begin
            m_g1 = {m_g1[9:1], m_g1[3] ^ m_g1[10]};
            m_g2 = {m_g2[9:1], m_g2[2] ^ m_g2[3] ^ m_g2[6] ^ m_g2[8] ^ m_g2[9] ^ m_g2[10]};
         end
      end
   endtask

   // Model update for one rising edge, using the inputs held across it.
   task automatic apply_edge();
      logic accept;
      logic advance;
      int   next_shift;
      int   prod_i;
      int   prod_q;
      int   inc;
      accept  = data_available_i && !m_seeking;
      advance = m_seeking || accept;
      exp_updating = pipe_valid[2];
      exp_complete = pipe_last[2];
      if (clear_i) begin
         m_acc_i = '0;
         m_acc_q = '0;
      end else if (pipe_valid[2]) begin
         m_acc_i = m_acc_i + 20'(pipe_i[2]);
         m_acc_q = m_acc_q + 20'(pipe_q[2]);
      end
      for (int s = 2; s > 0; s--) begin
         pipe_valid[s] = pipe_valid[s-1];
         pipe_last[s]  = pipe_last[s-1];
         pipe_i[s]     = pipe_i[s-1];
         pipe_q[s]     = pipe_q[s-1];
      end
      // Code and carrier before this sample's advance.
      prod_i = int'(data_i) * COS_TABLE[m_phase[15:13]];
      prod_q = int'(data_i) * SIN_TABLE[m_phase[15:13]];
      pipe_valid[0] = accept;
      pipe_last[0]  = accept && feed_complete_i;
      pipe_i[0]     = model_chip() ? -prod_i : prod_i;
      pipe_q[0]     = model_chip() ? -prod_q : prod_q;
      next_shift = (m_shift == SEEK_BOUND - 1) ? 0 : m_shift + 1;
      if (m_seeking) begin
         if (next_shift == m_target) begin
            m_seeking = 1'b0;
         end
      end else if (seek_en_i) begin
         m_seeking = 1'b1;
         m_target  = int'(seek_target_i);
      end
      if (advance) begin
         advance_code();
      end
      if (accept) begin
         inc     = 32'h2000 + int'(doppler_i);
         m_phase = m_phase + inc[15:0];
      end
   endtask

   task automatic compare_outputs();
      check_value(32'(seeking_o), 32'(m_seeking), "seeking_o");
      check_value(32'(code_shift_o), m_shift, "code_shift_o");
      check_value(32'(ca_bit_o), 32'(model_chip()), "ca_bit_o");
      check_value(32'(accumulator_updating_o), 32'(exp_updating), "accumulator_updating_o");
      check_value(32'(accumulation_complete_o), 32'(exp_complete), "accumulation_complete_o");
      check_value(32'(accumulator_i_o), 32'(m_acc_i), "accumulator_i_o");
      check_value(32'(accumulator_q_o), 32'(m_acc_q), "accumulator_q_o");
   endtask

   // Inputs are set 2 ns after an edge; this returns at the same point of the next cycle.
   task automatic tick();
      @(posedge clk_i);
      apply_edge();
      #1;
      compare_outputs();
      #1;
   endtask

   task automatic idle_inputs();
      clear_i          = 1'b0;
      data_available_i = 1'b0;
      feed_complete_i  = 1'b0;
      seek_en_i        = 1'b0;
   endtask

   task automatic random_inputs(input int strobe_odds, input int clear_odds);
      data_available_i = ({$random(seed)} % strobe_odds) == 0;
      feed_complete_i  = ({$random(seed)} % 6) == 0;
      data_i           = signal_pkg::sample_t'($random(seed));
      doppler_i        = signal_pkg::doppler_t'($random(seed));
      seek_en_i        = 1'b0;
      clear_i          = 1'b0;
      if (clear_odds > 0) begin
         clear_i = ({$random(seed)} % clear_odds) == 0;
      end
   endtask

   task automatic apply_reset(input int prn);
      idle_inputs();
      reset_i = 1'b1;
      prn_i   = code_pkg::prn_t'(prn);
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      reset_i      = 1'b0;
      m_prn        = prn;
      m_g1         = '1;
      m_g2         = '1;
      m_shift      = 0;
      m_seeking    = 1'b0;
      m_phase      = '0;
      m_acc_i      = '0;
      m_acc_q      = '0;
      exp_updating = 1'b0;
      exp_complete = 1'b0;
      for (int s = 0; s < 3; s++) begin
         pipe_valid[s] = 1'b0;
         pipe_last[s]  = 1'b0;
      end
      compare_outputs();
   endtask

   task automatic run_seek();
      int target;
      int waited;
      target = {$random(seed)} % SEEK_BOUND;
      idle_inputs();
      seek_en_i     = 1'b1;
      seek_target_i = code_pkg::code_shift_t'(target);
      tick();
      seek_en_i = 1'b0;
      check_value(32'(seeking_o), 32'd1, "seeking_o after seek_en_i");
      waited = 0;
      while (seeking_o) begin
         tick();
         waited++;
      end
      check_value(32'(waited <= SEEK_BOUND), 32'd1, "seek finished within 2046 cycles");
      check_value(32'(code_shift_o), target, "code_shift_o after seek");
   endtask

   initial begin
      seed             = 32'hdea68ce6;
      reset_i          = 1'b1;
      clear_i          = 1'b0;
      data_available_i = 1'b0;
      feed_complete_i  = 1'b0;
      data_i           = '0;
      doppler_i        = '0;
      prn_i            = '0;
      seek_en_i        = 1'b0;
      seek_target_i    = '0;
      apply_reset(0);
      for (int i = 0; i < PRN1_SAMPLES; i++) begin
         check_value(32'(ca_bit_o), 32'(PRN1_FIRST_CHIPS[9 - i / 2]), "PRN 1 chip");
         random_inputs(1, 0);
         tick();
      end
      // Random PRN, one sample per cycle through the code wrap.
      apply_reset({$random(seed)} % 32);
      repeat (PERIOD_CYCLES) begin
         random_inputs(1, 0);
         tick();
      end
      repeat (RANDOM_CYCLES) begin
         random_inputs(3, 40);
         tick();
      end
      repeat (NUM_SEEKS) begin
         run_seek();
         repeat (AFTER_SEEK_CYCLES) begin
            random_inputs(2, 40);
            tick();
         end
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

/* tb/subchannel_properties.sv */
`timescale 1ns/1ps

module subchannel_properties (
   input logic                  clk_i,
   input logic                  reset_i,
   input logic                  seeking_o,
   input code_pkg::code_shift_t code_shift_o,
   input logic                  accumulator_updating_o,
   input logic                  accumulation_complete_o
);

   // A feed can only complete on an accumulator update.
   complete_with_update: assert property (
      @(posedge clk_i) accumulation_complete_o |-> accumulator_updating_o
   ) else $error("accumulation_complete_o is high without accumulator_updating_o");

   // The code shift never leaves the code period.
   shift_in_period: assert property (
      @(posedge clk_i) disable iff (reset_i)
      code_shift_o < code_pkg::CODE_SAMPLES
   ) else $error("code_shift_o is outside the code period");

   // No seek is in progress during reset or in the first cycle after it.
   no_seek_after_reset: assert property (
      @(posedge clk_i) reset_i |=> !seeking_o
   ) else $error("seeking_o is high during or right after reset");

endmodule

bind subchannel subchannel_properties properties_inst (
   .clk_i                   (clk_i),
   .reset_i                 (reset_i),
   .seeking_o               (seeking_o),
   .code_shift_o            (code_shift_o),
   .accumulator_updating_o  (accumulator_updating_o),
   .accumulation_complete_o (accumulation_complete_o)
);

/* rtl/subchannel.sv */
`timescale 1ns/1ps

module subchannel (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  clear_i,
   input  logic                  data_available_i,
   input  logic                  feed_complete_i,
   input  signal_pkg::sample_t   data_i,
   input  signal_pkg::doppler_t  doppler_i,
   input  code_pkg::prn_t        prn_i,
   input  logic                  seek_en_i,
   input  code_pkg::code_shift_t seek_target_i,
   output logic                  seeking_o,
   output code_pkg::code_shift_t code_shift_o,
   output logic                  ca_bit_o,
   output logic                  accumulator_updating_o,
   output signal_pkg::acc_t      accumulator_i_o,
   output signal_pkg::acc_t      accumulator_q_o,
   output logic                  accumulation_complete_o
);

   logic                     sample_step;
   signal_pkg::carrier_t     carrier_i;
   signal_pkg::carrier_t     carrier_q;
   signal_pkg::align_stage_t align_d;
   signal_pkg::align_stage_t align_q;
   signal_pkg::mix_stage_t   mix_d;
   signal_pkg::mix_stage_t   mix_q;
   signal_pkg::mix_stage_t   post_mix_q;
   logic                     updating_q;
   logic                     complete_q;

   // Samples are dropped while the code is slewing.
   assign sample_step = data_available_i && !seeking_o;

   ca_upsampler upsampler (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .step_i        (sample_step),
      .prn_i         (prn_i),
      .seek_en_i     (seek_en_i),
      .seek_target_i (seek_target_i),
      .seeking_o     (seeking_o),
      .code_shift_o  (code_shift_o),
      .ca_bit_o      (ca_bit_o)
   );

   carrier_nco carrier_gen (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .step_i      (sample_step),
      .doppler_i   (doppler_i),
      .carrier_i_o (carrier_i),
      .carrier_q_o (carrier_q)
   );

   // Stage 0 takes code and carrier before both advance for this sample.
   always_comb begin
      align_d.valid     = sample_step;
      align_d.last      = sample_step && feed_complete_i;
      align_d.ca_bit    = ca_bit_o;
      align_d.sample    = data_i;
      align_d.carrier_i = carrier_i;
      align_d.carrier_q = carrier_q;
   end

   // Stage 1 carrier wipe-off.
   always_comb begin
      mix_d.valid  = align_q.valid;
      mix_d.last   = align_q.last;
      mix_d.ca_bit = align_q.ca_bit;
      mix_d.prod_i = signal_pkg::product_t'(align_q.sample)
                   * signal_pkg::product_t'(align_q.carrier_i);
      mix_d.prod_q = signal_pkg::product_t'(align_q.sample)
                   * signal_pkg::product_t'(align_q.carrier_q);
   end

   // Stage 2 retimes the products ahead of the accumulators.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         align_q.valid    <= 1'b0;
         align_q.last     <= 1'b0;
         mix_q.valid      <= 1'b0;
         mix_q.last       <= 1'b0;
         post_mix_q.valid <= 1'b0;
         post_mix_q.last  <= 1'b0;
         updating_q       <= 1'b0;
         complete_q       <= 1'b0;
      end else begin
         align_q    <= align_d;
         mix_q      <= mix_d;
         post_mix_q <= mix_q;
         updating_q <= post_mix_q.valid;
         complete_q <= post_mix_q.last;
      end
   end

   track track_i_arm (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .clear_i       (clear_i),
      .valid_i       (post_mix_q.valid),
      .ca_bit_i      (post_mix_q.ca_bit),
      .product_i     (post_mix_q.prod_i),
      .accumulator_o (accumulator_i_o)
   );

   track track_q_arm (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .clear_i       (clear_i),
      .valid_i       (post_mix_q.valid),
      .ca_bit_i      (post_mix_q.ca_bit),
      .product_i     (post_mix_q.prod_q),
      .accumulator_o (accumulator_q_o)
   );

   // Updating flags line up with the new accumulator values.
   assign accumulator_updating_o  = updating_q;
   assign accumulation_complete_o = complete_q;

endmodule

/* rtl/track.sv */
`timescale 1ns/1ps

module track (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 clear_i,
   input  logic                 valid_i,
   input  logic                 ca_bit_i,
   input  signal_pkg::product_t product_i,
   output signal_pkg::acc_t     accumulator_o
);

   signal_pkg::acc_t product_ext;
   signal_pkg::acc_t wiped;
   signal_pkg::acc_t acc_q;

   assign product_ext = signal_pkg::acc_t'(product_i);

   // Code wipe-off, a one chip flips the sign.
   assign wiped = ca_bit_i ? -product_ext : product_ext;

   // Clear has priority over an update in the same cycle.
   always_ff @(posedge clk_i) begin
      if (reset_i || clear_i) begin
         acc_q <= '0;
      end else if (valid_i) begin
         acc_q <= acc_q + wiped;
      end
   end

   assign accumulator_o = acc_q;

endmodule

/* rtl/carrier_nco.sv */
`timescale 1ns/1ps

module carrier_nco (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 step_i,
   input  signal_pkg::doppler_t doppler_i,
   output signal_pkg::carrier_t carrier_i_o,
   output signal_pkg::carrier_t carrier_q_o
);

   signal_pkg::phase_t     phase_q;
   signal_pkg::phase_t     phase_inc;
   signal_pkg::lut_index_t lut_index;

   // IF plus the two's complement Doppler offset, sign extended.
   assign phase_inc = signal_pkg::F_IF_INC + signal_pkg::phase_t'(doppler_i);

   // One phase step per accepted sample.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         phase_q <= '0;
      end else if (step_i) begin
         phase_q <= phase_q + phase_inc;
      end
   end

   // Table address is the top three phase bits.
   assign lut_index = phase_q[$bits(signal_pkg::phase_t)-1 -: $bits(signal_pkg::lut_index_t)];

   // The outputs hold the value for the sample about to be accepted.
   assign carrier_i_o = signal_pkg::COS_LUT[lut_index];
   assign carrier_q_o = signal_pkg::SIN_LUT[lut_index];

endmodule

/* rtl/ca_upsampler.sv */
`timescale 1ns/1ps

module ca_upsampler (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  step_i,
   input  code_pkg::prn_t        prn_i,
   input  logic                  seek_en_i,
   input  code_pkg::code_shift_t seek_target_i,
   output logic                  seeking_o,
   output code_pkg::code_shift_t code_shift_o,
   output logic                  ca_bit_o
);

   code_pkg::upsampler_state_t state_q;
   code_pkg::upsampler_state_t state_d;
   code_pkg::g2_taps_t         taps_q;
   code_pkg::lfsr_t            g1_q;
   code_pkg::lfsr_t            g1_d;
   code_pkg::lfsr_t            g2_q;
   code_pkg::lfsr_t            g2_d;
   code_pkg::chip_sample_t     sample_q;
   code_pkg::chip_sample_t     sample_d;
   code_pkg::code_shift_t      shift_q;
   code_pkg::code_shift_t      shift_d;
   code_pkg::code_shift_t      target_q;
   logic                       advance;
   logic                       code_wrap;
   logic                       chip_end;

   // The PRN is taken only while in reset.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         taps_q <= code_pkg::G2_TAPS[prn_i];
      end
   end

   // A seek slews the code one sample per cycle.
   assign advance = (state_q == code_pkg::SEEKING) || step_i;

   assign code_wrap = (shift_q == code_pkg::code_shift_t'(code_pkg::CODE_SAMPLES - 1));
   assign chip_end  = (sample_q == code_pkg::chip_sample_t'(code_pkg::SAMPLES_PER_CHIP - 1));

   always_comb begin
      g1_d     = g1_q;
      g2_d     = g2_q;
      sample_d = sample_q;
      shift_d  = shift_q;
      if (advance) begin
         if (code_wrap) begin
            // New code period, both registers back to all ones.
            g1_d     = code_pkg::LFSR_INIT;
            g2_d     = code_pkg::LFSR_INIT;
            sample_d = '0;
            shift_d  = '0;
         end else begin
            shift_d = shift_q + 1'b1;
            if (chip_end) begin
               sample_d = '0;
               g1_d = {g1_q[code_pkg::LFSR_WIDTH-2:0], ^(g1_q & code_pkg::G1_FEEDBACK)};
               g2_d = {g2_q[code_pkg::LFSR_WIDTH-2:0], ^(g2_q & code_pkg::G2_FEEDBACK)};
            end else begin
               sample_d = sample_q + 1'b1;
            end
         end
      end
   end

   // Seeking ends on the edge that lands on the target.
   always_comb begin
      state_d = state_q;
      case (state_q)
         code_pkg::TRACKING: begin
            if (seek_en_i) begin
               state_d = code_pkg::SEEKING;
            end
         end
         code_pkg::SEEKING: begin
            if (shift_d == target_q) begin
               state_d = code_pkg::TRACKING;
            end
         end
         default: begin
            state_d = code_pkg::TRACKING;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= code_pkg::TRACKING;
         g1_q     <= code_pkg::LFSR_INIT;
         g2_q     <= code_pkg::LFSR_INIT;
         sample_q <= '0;
         shift_q  <= '0;
      end else begin
         state_q  <= state_d;
         g1_q     <= g1_d;
         g2_q     <= g2_d;
         sample_q <= sample_d;
         shift_q  <= shift_d;
      end
   end

   // Requests that arrive mid-seek are dropped.
   always_ff @(posedge clk_i) begin
      if ((state_q == code_pkg::TRACKING) && seek_en_i) begin
         target_q <= seek_target_i;
      end
   end

   // Chip is G1 stage 10 against the two PRN-selected G2 stages.
   assign ca_bit_o = g1_q[code_pkg::LFSR_WIDTH-1]
                   ^ g2_q[taps_q.tap_a - 4'd1]
                   ^ g2_q[taps_q.tap_b - 4'd1];

   assign seeking_o    = (state_q == code_pkg::SEEKING);
   assign code_shift_o = shift_q;

endmodule

/* rtl/signal_pkg.sv */
package signal_pkg;

   // Two-bit magnitude plus sign from the front end.
   typedef logic signed [2:0] sample_t;

   // Doppler offset in phase-increment units.
   typedef logic signed [9:0] doppler_t;

   // Carrier phase accumulator and its nominal IF increment.
   typedef logic [15:0] phase_t;
   localparam phase_t F_IF_INC = 16'h2000;

   // The top phase bits address the carrier tables.
   typedef logic [2:0] lut_index_t;
   localparam int LUT_ENTRIES = 8;

   typedef logic signed [2:0] carrier_t;

   // One carrier cycle in eight steps.
   localparam carrier_t COS_LUT [LUT_ENTRIES] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };
   localparam carrier_t SIN_LUT [LUT_ENTRIES] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

   // Sample times carrier, worst case is -4 * -2.
   typedef logic signed [5:0] product_t;

   // Correlation sums, wrapping modulo 2^20.
   typedef logic signed [19:0] acc_t;

   // Sample with the code bit and carrier values that belong to it.
   typedef struct packed {
      logic     valid;
      logic     last;
      logic     ca_bit;
      sample_t  sample;
      carrier_t carrier_i;
      carrier_t carrier_q;
   } align_stage_t;

   // Carrier-wiped sample, code still present.
   typedef struct packed {
      logic     valid;
      logic     last;
      logic     ca_bit;
      product_t prod_i;
      product_t prod_q;
   } mix_stage_t;

endpackage

/* rtl/code_pkg.sv */
package code_pkg;

   // PRN number, value 0 selects PRN 1.
   localparam int PRN_WIDTH = 5;
   typedef logic [PRN_WIDTH-1:0] prn_t;

   localparam int CHIPS_PER_CODE = 1023;
   localparam int SAMPLES_PER_CHIP = 2;
   localparam int CODE_SAMPLES = CHIPS_PER_CODE * SAMPLES_PER_CHIP;

   // Sample index within one code period, 0 to CODE_SAMPLES-1.
   typedef logic [10:0] code_shift_t;

   // Sample position within the current chip.
   typedef logic [$clog2(SAMPLES_PER_CHIP)-1:0] chip_sample_t;

   // Both Gold code registers are 10 stages, bit n-1 holds stage n.
   localparam int LFSR_WIDTH = 10;
   typedef logic [LFSR_WIDTH-1:0] lfsr_t;
   localparam lfsr_t LFSR_INIT = '1;

   // G1 is x^10+x^3+1, so stages 3 and 10 feed back.
   localparam lfsr_t G1_FEEDBACK = 10'b10_0000_0100;
   // G2 is x^10+x^9+x^8+x^6+x^3+x^2+1.
   localparam lfsr_t G2_FEEDBACK = 10'b11_1010_0110;

   // Pair of G2 stages (1 to 10) that form the PRN's delayed G2 sequence.
   typedef logic [3:0] g2_stage_t;
   typedef struct packed {
      g2_stage_t tap_a;
      g2_stage_t tap_b;
   } g2_taps_t;

   localparam g2_taps_t G2_TAPS [32] = '{
      '{4'd2, 4'd6},  '{4'd3, 4'd7},  '{4'd4, 4'd8},  '{4'd5, 4'd9},
      '{4'd1, 4'd9},  '{4'd2, 4'd10}, '{4'd1, 4'd8},  '{4'd2, 4'd9},
      '{4'd3, 4'd10}, '{4'd2, 4'd3},  '{4'd3, 4'd4},  '{4'd5, 4'd6},
      '{4'd6, 4'd7},  '{4'd7, 4'd8},  '{4'd8, 4'd9},  '{4'd9, 4'd10},
      '{4'd1, 4'd4},  '{4'd2, 4'd5},  '{4'd3, 4'd6},  '{4'd4, 4'd7},
      '{4'd5, 4'd8},  '{4'd6, 4'd9},  '{4'd1, 4'd3},  '{4'd4, 4'd6},
      '{4'd5, 4'd7},  '{4'd6, 4'd8},  '{4'd7, 4'd9},  '{4'd8, 4'd10},
      '{4'd1, 4'd6},  '{4'd2, 4'd7},  '{4'd3, 4'd8},  '{4'd4, 4'd9}
   };

   typedef enum logic {
      TRACKING,
      SEEKING
   } upsampler_state_t;

endpackage
